// ==== flacLpc.f ====
rtl/flacCfgPkg.sv
rtl/flacTypesPkg.sv
rtl/sampleRam.sv
rtl/sampleArbiter.sv
rtl/lpcPredictor.sv
rtl/pcmReader.sv
rtl/flacLpcTop.sv
bench/flacLpcChk.sv
bench/flacLpcTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Verilator build and run, the exit status carries the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module flacLpcTb -f flacLpc.f --Mdir obj_dir
./obj_dir/VflacLpcTb

// ==== bench/flacLpcTb.sv ====
`timescale 1ns/1ps

module flacLpcTb
    import flacCfgPkg::*, flacTypesPkg::*;
();

    localparam int numSubframes = 8;
    localparam int resPerSubframe = 16;
    // forty words of sixteen cycles per subframe plus reset and drain.
    localparam int timeoutCycles = numSubframes * 40 * 16 + 200;

    logic iClock = 1'b0;
    logic rstN;
    logic start;
    lpcCfgT cfg;
    logic wordValid;
    subframeWordT word;
    logic busy;
    logic pcmValid;
    logic signed [sampleWidth-1:0] pcm;

    // reference model with history 0 as the newest sample.
    logic [31:0] lfsr = 32'h12ce_018e;
    int coefModel [maxOrder];
    logic signed [sampleWidth-1:0] histModel [maxOrder];
    logic signed [sampleWidth-1:0] expQ [$];
    int cycleCount = 0;

    flacLpcTop i_flacLpcTop (.*);

    always #4 iClock = ~iClock;

    task automatic stopOnError(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // galois step with taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsrBit();
        logic out;
        out = lfsr[0];
        lfsr = (lfsr >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic int randBits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsrBit());
        end
        return v;
    endfunction

    // n-bit two's complement value.
    function automatic int randSigned(int n);
        int v;
        v = randBits(n);
        return v[n-1] ? v - (1 << n) : v;
    endfunction

    task automatic pushSample(logic signed [sampleWidth-1:0] s);
        for (int k = maxOrder - 1; k > 0; k--) begin
            histModel[k] = histModel[k-1];
        end
        histModel[0] = s;
        expQ.push_back(s);
    endtask

    task automatic driveWord(subframeWordT w);
        @(posedge iClock);
        start <= 1'b0;
        wordValid <= 1'b1;
        word <= w;
    endtask

    // busy is sampled mid-cycle where it is stable.
    task automatic waitReady();
        @(negedge iClock);
        while (busy) begin
            @(negedge iClock);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one subframe with its start pulse, header words and residuals
    ////////////////////////////////////////////////////////////////////////////

    task automatic runSubframe(int order, int shift, bit unitCoef);
        subframeWordT w;
        longint sum;
        int r;
        waitReady();
        @(posedge iClock);
        start <= 1'b1;
        cfg.order <= orderWidth'(order);
        cfg.shift <= shiftWidth'(shift);
        for (int k = 0; k < order; k++) begin
            coefModel[k] = unitCoef ? 1 : randSigned(12);
            w.coeff = coefModel[k];
            driveWord(w);
        end
        // random padding that the predictor must ignore.
        for (int k = 0; k < order; k++) begin
            w.smp.pad = 16'(randBits(16));
            w.smp.sample = unitCoef ? 16'sd32600 : 16'(randSigned(16));
            pushSample(w.smp.sample);
            driveWord(w);
        end
        @(posedge iClock);
        wordValid <= 1'b0;
        for (int n = 0; n < resPerSubframe; n++) begin
            // unit subframe climbs past the positive limit and wraps.
            r = unitCoef ? 300 + randBits(7) : randSigned(10);
            sum = 0;
            for (int k = 0; k < order; k++) begin
                sum += longint'(coefModel[k]) * longint'(histModel[k]);
            end
            sum = (sum >>> shift) + longint'(r);
            pushSample(16'(sum));
            w = '0;
            w.smp.sample = 16'(r);
            waitReady();
            @(posedge iClock);
            wordValid <= 1'b1;
            word <= w;
            @(posedge iClock);
            wordValid <= 1'b0;
        end
    endtask

    // every strobe must match the oldest expected sample.
    always @(negedge iClock) begin
        if (rstN && pcmValid) begin
            assert (expQ.size() != 0)
                else stopOnError($sformatf("Fail at %0t: unexpected pcm sample %0d",
                                           $time, pcm));
            assert (pcm === expQ[0])
                else stopOnError($sformatf("Fail at %0t: pcm %0d, expected %0d",
                                           $time, pcm, expQ[0]));
            void'(expQ.pop_front());
        end
    end

    always @(posedge iClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            stopOnError($sformatf("run timed out after %0d cycles", cycleCount));
        end
    end

    initial begin
        rstN = 1'b0;
        start = 1'b0;
        cfg = '0;
        wordValid = 1'b0;
        word = '0;
        repeat (4) @(posedge iClock);
        rstN <= 1'b1;
        // quiet after reset with no stimulus.
        repeat (16) begin
            @(negedge iClock);
            assert (!pcmValid && !busy)
                else stopOnError($sformatf("Fail at %0t: pcmValid or busy high after reset",
                                           $time));
        end
        runSubframe(1, 0, 1'b1);
        runSubframe(maxOrder, randBits(5), 1'b0);
        for (int s = 2; s < numSubframes; s++) begin
            runSubframe(1 + randBits(4) % maxOrder, randBits(5), 1'b0);
        end
        while (expQ.size() != 0) begin
            @(posedge iClock);
        end
        // no stray strobes after the last sample.
        repeat (20) @(posedge iClock);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== bench/flacLpcChk.sv ====
`timescale 1ns/1ps

module flacLpcChk
    import flacCfgPkg::*, flacTypesPkg::*;
(
    input logic   iClock,
    input logic   rstN,
    input logic   start,
    input lpcCfgT cfg,
    input logic   wordValid,
    input logic   busy,
    input logic   writeGrant,
    input logic   readGrant,
    input logic   pcmValid
);

    // coefficient and warmup words still due, zero means residual slot.
    logic [orderWidth:0] wordsLeft;
    // cycles busy has stayed high since a residual was taken.
    logic [4:0] resBusy;

    always_ff @(posedge iClock or negedge rstN) begin
        if (!rstN) begin
            wordsLeft <= '0;
            resBusy <= '0;
        end else begin
            if (start) begin
                wordsLeft <= {cfg.order, 1'b0};
            end else if (wordValid && (wordsLeft != '0)) begin
                wordsLeft <= wordsLeft - 1'b1;
            end
            if (!start && wordValid && (wordsLeft == '0)) begin
                resBusy <= 5'd1;
            end else if (busy && (resBusy != '0)) begin
                resBusy <= resBusy + 1'b1;
            end else begin
                resBusy <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // protocol and arbitration
    ////////////////////////////////////////////////////////////////////////////

    // single RAM port, one grant at a time.
    assert property (@(posedge iClock) disable iff (!rstN) !(writeGrant && readGrant))
        else $error("write grant and read grant were high together");

    // the source may only send a residual while busy is low.
    assert property (@(posedge iClock) disable iff (!rstN) (wordValid && (wordsLeft == '0)) |-> !busy)
        else $error("residual word arrived while busy was high");

    // one cycle per tap plus the write, then the grant.
    assert property (@(posedge iClock) disable iff (!rstN) resBusy <= 5'(maxOrder + 3))
        else $error("busy stayed high too long after a residual");

    assert property (@(posedge iClock) disable iff (!rstN) !$isunknown(pcmValid))
        else $error("pcmValid was unknown after reset");

endmodule

bind flacLpcTop flacLpcChk i_flacLpcChk (.*);

// ==== rtl/flacLpcTop.sv ====
`timescale 1ns/1ps

module flacLpcTop
    import flacCfgPkg::*, flacTypesPkg::*;
(
    input  logic                          iClock,
    input  logic                          rstN,
    input  logic                          start,
    input  lpcCfgT                        cfg,
    input  logic                          wordValid,
    input  subframeWordT                  word,
    output logic                          busy,
    output logic                          pcmValid,
    output logic signed [sampleWidth-1:0] pcm
);

    // predictor to arbiter.
    logic writeReq;
    logic signed [sampleWidth-1:0] writeData;
    logic writeGrant;
    // reader to arbiter.
    logic readReq;
    logic [ramAddrWidth-1:0] readAddr;
    logic readGrant;
    logic [ramAddrWidth-1:0] writeAddr;
    // arbiter to RAM and back.
    ramReqT ramReq;
    logic signed [sampleWidth-1:0] readData;

    lpcPredictor i_lpcPredictor (
        .iClock     (iClock),
        .rstN       (rstN),
        .start      (start),
        .cfg        (cfg),
        .wordValid  (wordValid),
        .word       (word),
        .busy       (busy),
        .writeReq   (writeReq),
        .writeData  (writeData),
        .writeGrant (writeGrant)
    );

    sampleArbiter i_sampleArbiter (
        .iClock     (iClock),
        .rstN       (rstN),
        .writeReq   (writeReq),
        .writeData  (writeData),
        .writeGrant (writeGrant),
        .readReq    (readReq),
        .readAddr   (readAddr),
        .readGrant  (readGrant),
        .writeAddr  (writeAddr),
        .ramReq     (ramReq)
    );

    sampleRam i_sampleRam (
        .iClock   (iClock),
        .ramReq   (ramReq),
        .readData (readData)
    );

    pcmReader i_pcmReader (
        .iClock    (iClock),
        .rstN      (rstN),
        .writeAddr (writeAddr),
        .readReq   (readReq),
        .readAddr  (readAddr),
        .readGrant (readGrant),
        .readData  (readData),
        .pcmValid  (pcmValid),
        .pcm       (pcm)
    );

endmodule

// ==== rtl/pcmReader.sv ====
`timescale 1ns/1ps

module pcmReader
    import flacCfgPkg::*;
(
    input  logic                          iClock,
    input  logic                          rstN,
    input  logic [ramAddrWidth-1:0]       writeAddr,
    output logic                          readReq,
    output logic [ramAddrWidth-1:0]       readAddr,
    input  logic                          readGrant,
    input  logic signed [sampleWidth-1:0] readData,
    output logic                          pcmValid,
    output logic signed [sampleWidth-1:0] pcm
);

    // next sample to stream out.
    logic [ramAddrWidth-1:0] readPtr;
    // RAM data is valid in this cycle.
    logic dataPending;

    // unread samples exist whenever the pointers differ.
    assign readReq = (readPtr != writeAddr);
    assign readAddr = readPtr;

    ////////////////////////////////////////////////////////////////////////////
    // read pointer and output strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge iClock or negedge rstN) begin
        if (!rstN) begin
            readPtr <= '0;
            dataPending <= 1'b0;
            pcmValid <= 1'b0;
        end else begin
            // wraps at ramDepth, same as the write pointer.
            if (readGrant) begin
                if (readPtr == ramAddrWidth'(ramDepth - 1)) begin
                    readPtr <= '0;
                end else begin
                    readPtr <= readPtr + 1'b1;
                end
            end
            dataPending <= readGrant;
            pcmValid <= dataPending;
        end
    end

    // pcm lines up with pcmValid.
    always_ff @(posedge iClock) begin
        if (dataPending) begin
            pcm <= readData;
        end
    end

endmodule

// ==== rtl/lpcPredictor.sv ====
`timescale 1ns/1ps

module lpcPredictor
    import flacCfgPkg::*, flacTypesPkg::*;
(
    input  logic                          iClock,
    input  logic                          rstN,
    input  logic                          start,
    input  lpcCfgT                        cfg,
    input  logic                          wordValid,
    input  subframeWordT                  word,
    output logic                          busy,
    output logic                          writeReq,
    output logic signed [sampleWidth-1:0] writeData,
    input  logic                          writeGrant
);

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    // phase of the current subframe.
    // phWrite is the shift, add and truncate cycle that issues the write.
    enum logic [2:0] {
        phIdle,
        phCoef,
        phWarm,
        phResWait,
        phMac,
        phWrite
    } phase;

    // configuration latched on start.
    lpcCfgT cfgQ;
    // word counter for the coefficient and warmup phases.
    logic [orderWidth-1:0] count;
    // tap index of the single multiplier.
    logic [orderWidth-1:0] tap;

    // coefficient k pairs with history k, history 0 being the newest sample.
    logic signed [coeffWidth-1:0] coeffs [maxOrder];
    logic signed [sampleWidth-1:0] history [maxOrder];

    logic signed [sampleWidth-1:0] residual;
    logic signed [accWidth-1:0] acc;

    logic signed [sampleWidth+coeffWidth-1:0] product;
    logic signed [accWidth-1:0] sumShifted;
    logic signed [accWidth-1:0] predSum;
    logic signed [sampleWidth-1:0] histIn;
    logic lastWord;
    logic accept;
    logic pushHist;

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    // one multiplier stepped over the taps.
    // tap sits at zero while waiting, so the accept cycle does tap 0.
    assign product = history[tap] * coeffs[tap];

    // arithmetic shift keeps negative sums negative.
    assign sumShifted = acc >>> cfgQ.shift;
    assign predSum = sumShifted + accWidth'(residual);

    // warmups pass through, residuals get the prediction added.
    assign histIn = (phase == phWarm) ? word.smp.sample : predSum[sampleWidth-1:0];

    // last coefficient or warmup of the subframe.
    assign lastWord = (count == cfgQ.order - 1'b1);

    // a residual is only taken while busy is low.
    assign accept = !start && (phase == phResWait) && wordValid && !busy;

    // new sample into history and out to the RAM.
    assign pushHist = !start && (((phase == phWarm) && wordValid) || (phase == phWrite));

    ////////////////////////////////////////////////////////////////////////////
    // phase machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge iClock or negedge rstN) begin
        if (!rstN) begin
            phase <= phIdle;
            cfgQ <= '0;
            count <= '0;
            tap <= '0;
            busy <= 1'b0;
        end else if (start) begin
            // a start restarts from any phase.
            phase <= phCoef;
            cfgQ <= cfg;
            count <= '0;
            tap <= '0;
            busy <= 1'b1;
        end else begin
            case (phase)
                phCoef: begin
                    if (wordValid) begin
                        count <= lastWord ? '0 : count + 1'b1;
                        if (lastWord) begin
                            phase <= phWarm;
                        end
                    end
                end
                phWarm: begin
                    if (wordValid) begin
                        count <= lastWord ? '0 : count + 1'b1;
                        // busy stays up until the last warmup is written.
                        if (lastWord) begin
                            phase <= phResWait;
                        end
                    end
                end
                phResWait: begin
                    // pending write done, source may send the next residual.
                    if (writeGrant) begin
                        busy <= 1'b0;
                    end
                    if (accept) begin
                        busy <= 1'b1;
                        tap <= tap + 1'b1;
                        // order 1 has no taps left after the accept cycle.
                        phase <= (cfgQ.order == 1) ? phWrite : phMac;
                    end
                end
                phMac: begin
                    tap <= tap + 1'b1;
                    if (tap == cfgQ.order - 1'b1) begin
                        phase <= phWrite;
                    end
                end
                phWrite: begin
                    tap <= '0;
                    phase <= phResWait;
                end
                default: begin
                    phase <= phIdle;
                end
            endcase
        end
    end

    // write request is a level held until the arbiter grants it.
    always_ff @(posedge iClock or negedge rstN) begin
        if (!rstN) begin
            writeReq <= 1'b0;
        end else if (pushHist) begin
            writeReq <= 1'b1;
        end else if (writeGrant) begin
            writeReq <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge iClock) begin
        if (!start && (phase == phCoef) && wordValid) begin
            coeffs[count] <= word.coeff;
        end
        // shift register, oldest sample falls off the end.
        if (pushHist) begin
            for (int i = maxOrder - 1; i > 0; i--) begin
                history[i] <= history[i-1];
            end
            history[0] <= histIn;
        end
    end

    // accumulator and payload registers.
    always_ff @(posedge iClock) begin
        if (accept) begin
            residual <= word.smp.sample;
            acc <= accWidth'(product);
        end else if (phase == phMac) begin
            acc <= acc + accWidth'(product);
        end
        // truncation to the sample width happens here.
        if (pushHist) begin
            writeData <= histIn;
        end
    end

endmodule

// ==== rtl/sampleArbiter.sv ====
`timescale 1ns/1ps

module sampleArbiter
    import flacCfgPkg::*, flacTypesPkg::*;
(
    input  logic                          iClock,
    input  logic                          rstN,
    // writer side, the predictor.
    input  logic                          writeReq,
    input  logic signed [sampleWidth-1:0] writeData,
    output logic                          writeGrant,
    // reader side, the pcm streamer.
    input  logic                          readReq,
    input  logic [ramAddrWidth-1:0]       readAddr,
    output logic                          readGrant,
    // write pointer, also the fill mark seen by the reader.
    output logic [ramAddrWidth-1:0]       writeAddr,
    output ramReqT                        ramReq
);

    ////////////////////////////////////////////////////////////////////////////
    // fixed priority grant
    ////////////////////////////////////////////////////////////////////////////

    // writer always wins.
    // its request drops the cycle after the grant, so each grant is one cycle.
    assign writeGrant = writeReq;

    // reader only gets the port in a cycle without a write.
    assign readGrant = readReq & ~writeReq;

    ////////////////////////////////////////////////////////////////////////////
    // merged RAM command
    ////////////////////////////////////////////////////////////////////////////

    assign ramReq.writeEn = writeGrant;
    assign ramReq.readEn = readGrant;
    // address follows whoever holds the grant.
    assign ramReq.port.addr = writeGrant ? writeAddr : readAddr;
    // data only matters on a write.
    assign ramReq.port.data = writeData;

    ////////////////////////////////////////////////////////////////////////////
    // write pointer
    ////////////////////////////////////////////////////////////////////////////

    // advances once per granted write, wraps at ramDepth.
    always_ff @(posedge iClock or negedge rstN) begin
        if (!rstN) begin
            writeAddr <= '0;
        end else if (writeGrant) begin
            if (writeAddr == ramAddrWidth'(ramDepth - 1)) begin
                writeAddr <= '0;
            end else begin
                writeAddr <= writeAddr + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/sampleRam.sv ====
`timescale 1ns/1ps

module sampleRam
    import flacCfgPkg::*, flacTypesPkg::*;
(
    input  logic                          iClock,
    input  ramReqT                        ramReq,
    output logic signed [sampleWidth-1:0] readData
);

    // circular sample store, indexed by the arbiter's pointers.
    logic [sampleWidth-1:0] mem [ramDepth];

    // single port, write and read share the address.
    always_ff @(posedge iClock) begin
        if (ramReq.writeEn) begin
            mem[ramReq.port.addr] <= ramReq.port.data;
        end
    end

    // registered read.
    // data shows up the cycle after the read enable and then holds.
    always_ff @(posedge iClock) begin
        if (ramReq.readEn) begin
            readData <= mem[ramReq.port.addr];
        end
    end

endmodule

// ==== rtl/flacTypesPkg.sv ====
package flacTypesPkg;

    import flacCfgPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // subframe side
    ////////////////////////////////////////////////////////////////////////////

    // subframe configuration, sampled on the start pulse.
    typedef struct packed {
        logic [orderWidth-1:0] order;
        logic [shiftWidth-1:0] shift;
    } lpcCfgT;

    // warmup or residual as delivered by the parser.
    // upper half is padding and carries nothing.
    typedef struct packed {
        logic [coeffWidth-sampleWidth-1:0] pad;
        logic signed [sampleWidth-1:0] sample;
    } sampleWordT;

    // one parser word, read as a coefficient in the coefficient phase
    // and as a sample in the warmup and residual phases.
    typedef union packed {
        logic signed [coeffWidth-1:0] coeff;
        sampleWordT smp;
    } subframeWordT;

    ////////////////////////////////////////////////////////////////////////////
    // RAM side
    ////////////////////////////////////////////////////////////////////////////

    // address and data of one RAM access.
    typedef struct packed {
        logic [ramAddrWidth-1:0] addr;
        logic [sampleWidth-1:0] data;
    } ramWriteT;

    // merged command on the single RAM port.
    // at most one of the enables is high.
    typedef struct packed {
        logic writeEn;
        logic readEn;
        ramWriteT port;
    } ramReqT;

endpackage

// ==== rtl/flacCfgPkg.sv ====
package flacCfgPkg;

    ////////////////////////////////////////////////////////////////////////////
    // sample and coefficient dimensions
    ////////////////////////////////////////////////////////////////////////////

    // pcm sample width, also the width of warmups and residuals.
    localparam int sampleWidth = 16;
    // quantized coefficient width, arrives already sign-extended.
    localparam int coeffWidth = 32;
    // accumulator width, wide enough for twelve full products.
    localparam int accWidth = 64;

    // lpc order limits.
    localparam int maxOrder = 12;
    localparam int orderWidth = 4;
    // right shift applied to the predictor sum.
    localparam int shiftWidth = 5;

    ////////////////////////////////////////////////////////////////////////////
    // sample RAM
    ////////////////////////////////////////////////////////////////////////////

    // ring of decoded samples; depth is a power of two.
    localparam int ramDepth = 256;
    localparam int ramAddrWidth = 8;

endpackage
